// File: hw/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

   localparam int XLEN = 32;                 // register and immediate width

   typedef enum logic [4:0] {                // major opcode, instr[6:2]
      OP_LOAD    = 5'b00000,
      OP_MISCMEM = 5'b00011,                 // fence
      OP_OPIMM   = 5'b00100,
      OP_AUIPC   = 5'b00101,
      OP_STORE   = 5'b01000,
      OP_OP      = 5'b01100,
      OP_LUI     = 5'b01101,
      OP_BRANCH  = 5'b11000,
      OP_JALR    = 5'b11001,
      OP_JAL     = 5'b11011,
      OP_SYSTEM  = 5'b11100
   } opcode_e;

   localparam logic [2:0] F3_ADD_SUB = 3'b000;  // alu funct3, OP and OPIMM
   localparam logic [2:0] F3_SLL     = 3'b001;
   localparam logic [2:0] F3_SLT     = 3'b010;
   localparam logic [2:0] F3_SLTU    = 3'b011;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_SRL_SRA = 3'b101;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;

   localparam logic [2:0] F3_BEQ  = 3'b000;     // branch conditions
   localparam logic [2:0] F3_BNE  = 3'b001;
   localparam logic [2:0] F3_BLT  = 3'b100;
   localparam logic [2:0] F3_BGE  = 3'b101;
   localparam logic [2:0] F3_BLTU = 3'b110;
   localparam logic [2:0] F3_BGEU = 3'b111;

   localparam logic [2:0] F3_LW   = 3'b010;     // word load
   localparam logic [2:0] F3_SW   = 3'b010;     // word store
   localparam logic [2:0] F3_JALR = 3'b000;

   localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
   localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;  // sub / sra
   localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;  // m extension

   typedef enum logic [1:0] {C0 = 2'b00, C1 = 2'b01, C2 = 2'b10, FULL = 2'b11} c_quadrant_e;

   localparam logic [2:0] C0_F3_LW    = 3'b010;
   localparam logic [2:0] C0_F3_SW    = 3'b110;
   localparam logic [2:0] C1_F3_ADDI  = 3'b000;  // also c.nop
   localparam logic [2:0] C1_F3_JAL   = 3'b001;  // rv32 only
   localparam logic [2:0] C1_F3_LI    = 3'b010;
   localparam logic [2:0] C1_F3_LUI   = 3'b011;  // shared with addi16sp
   localparam logic [2:0] C1_F3_J     = 3'b101;
   localparam logic [2:0] C2_F3_SLLI  = 3'b000;
   localparam logic [2:0] C2_F3_LWSP  = 3'b010;
   localparam logic [2:0] C2_F3_JR_MV = 3'b100;  // jr, mv, ebreak, jalr, add
   localparam logic [2:0] C2_F3_SWSP  = 3'b110;

   localparam logic [4:0] REG_RA = 5'd1;
   localparam logic [4:0] REG_SP = 5'd2;

endpackage

`default_nettype wire

// File: hw/decode_pkg.sv
`default_nettype none

package decode_pkg;

   typedef enum logic [4:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_SLL,
      ALU_SLT,
      ALU_SLTU,
      ALU_XOR,
      ALU_SRL,
      ALU_SRA,
      ALU_OR,
      ALU_AND,
      ALU_MUL,                               // m extension from here on
      ALU_MULH,
      ALU_MULHSU,
      ALU_MULHU,
      ALU_DIV,
      ALU_DIVU,
      ALU_REM,
      ALU_REMU
   } alu_op_e;

   typedef enum logic {S1_REGVAL1 = 1'b0, S1_PC = 1'b1} alu_s1_sel_e;
   typedef enum logic [1:0] {S2_REGVAL2 = 2'd0, S2_IMM = 2'd1} alu_s2_sel_e;
   typedef enum logic [1:0] {REGIN_ALU = 2'd0, REGIN_IMM = 2'd1} reg_in_sel_e;

   typedef enum logic [2:0] {
      EXEC_FETCH = 3'd0,                     // zero so a cleared ctrl means fetch
      EXEC_LOAD,
      EXEC_STORE,
      EXEC_BRANCH,
      EXEC_SYSTEM,
      EXEC_TRAP
   } exec_stage_e;

   typedef struct packed {
      alu_s1_sel_e s1_sel;
      alu_s2_sel_e s2_sel;
      exec_stage_e next_stage;
      logic        wb_from_alu;              // writeback in fetch
      logic        wb_from_imm;
      logic        next_pc_from_alu;         // jumps
      reg_in_sel_e reg_in_sel;
      logic        write_reg;                // link register write in decode
   } exec_ctrl_t;

   typedef struct packed {
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [4:0]  rd;
      logic [31:0] imm;
      alu_op_e     alu_op;
      logic [5:0]  branch_mask;              // beq bne blt bge bltu bgeu
      logic [2:0]  funct3;
      exec_ctrl_t  ctrl;
   } decode_out_t;

endpackage

`default_nettype wire

// File: hw/rvc_expand.sv
`default_nettype none

module rvc_expand import rv_isa_pkg::*; (
   input  logic [31:0] i_instr,
   output logic [31:0] o_instr32,
   output logic        o_illegal
);

   logic [15:0] c;                           // compressed halfword
   logic [2:0]  c_f3;
   logic [4:0]  c_rd;                        // rd/rs1, full register field
   logic [4:0]  c_rs2;
   logic [4:0]  c_rs1p;                      // compact regs, x8..x15
   logic [4:0]  c_rs2p;
   logic [11:0] ci_imm;                      // signed 6-bit imm
   logic [20:0] cj_off;                      // c.j / c.jal target offset
   logic [11:0] cw_off;                      // c.lw / c.sw uimm
   logic [11:0] lwsp_off;
   logic [11:0] swsp_off;

   assign c      = i_instr[15:0];
   assign c_f3   = c[15:13];
   assign c_rd   = c[11:7];
   assign c_rs2  = c[6:2];
   assign c_rs1p = {2'b01, c[9:7]};
   assign c_rs2p = {2'b01, c[4:2]};
   assign ci_imm = {{7{c[12]}}, c[6:2]};
   assign cj_off = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
   assign cw_off   = {5'b0, c[5], c[12:10], c[6], 2'b00};
   assign lwsp_off = {4'b0, c[3:2], c[12], c[6:4], 2'b00};
   assign swsp_off = {4'b0, c[8:7], c[12:9], 2'b00};

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input opcode_e op);
      return {imm, rs1, f3, rd, op, 2'b11};
   endfunction

   function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OP_STORE, 2'b11};
   endfunction

   function automatic logic [31:0] enc_add(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [4:0] rd);
      return {FUNCT7_BASE, rs2, rs1, F3_ADD_SUB, rd, OP_OP, 2'b11};
   endfunction

   function automatic logic [31:0] enc_jal(input logic [20:0] off, input logic [4:0] rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL, 2'b11};
   endfunction

   always_comb begin
      o_instr32 = i_instr;                   // full length passes through
      o_illegal = 1'b0;
      case (c_quadrant_e'(c[1:0]))
         C0: begin
            case (c_f3)
               C0_F3_LW: o_instr32 = enc_i(cw_off, c_rs1p, F3_LW, c_rs2p, OP_LOAD);
               C0_F3_SW: o_instr32 = enc_s(cw_off, c_rs2p, c_rs1p);
               default:  o_illegal = 1'b1;   // addi4spn, fp, reserved
            endcase
         end
         C1: begin
            case (c_f3)
               C1_F3_ADDI: o_instr32 = enc_i(ci_imm, c_rd, F3_ADD_SUB, c_rd, OP_OPIMM);
               C1_F3_JAL:  o_instr32 = enc_jal(cj_off, REG_RA);
               C1_F3_J:    o_instr32 = enc_jal(cj_off, 5'd0);
               C1_F3_LI:   o_instr32 = enc_i(ci_imm, 5'd0, F3_ADD_SUB, c_rd, OP_OPIMM);
               C1_F3_LUI: begin
                  o_instr32 = {{8{c[12]}}, ci_imm, c_rd, OP_LUI, 2'b11};
                  // rd of sp is addi16sp, not kept
                  o_illegal = (c_rd == REG_SP) || (ci_imm == '0);
               end
               default: o_illegal = 1'b1;    // alu group, beqz, bnez
            endcase
         end
         C2: begin
            case (c_f3)
               C2_F3_SLLI: begin
                  o_instr32 = enc_i({FUNCT7_BASE, c_rs2}, c_rd, F3_SLL, c_rd, OP_OPIMM);
                  o_illegal = c[12];         // shamt[5] reserved on rv32
               end
               C2_F3_LWSP: begin
                  o_instr32 = enc_i(lwsp_off, REG_SP, F3_LW, c_rd, OP_LOAD);
                  o_illegal = (c_rd == '0);
               end
               C2_F3_JR_MV: begin
                  if (c_rs2 != '0) begin     // mv reads x0, add reads rd
                     o_instr32 = enc_add(c_rs2, c[12] ? c_rd : 5'd0, c_rd);
                  end else begin             // jr links to x0, jalr to ra
                     o_instr32 = enc_i(12'd0, c_rd, F3_JALR, c[12] ? REG_RA : 5'd0, OP_JALR);
                     o_illegal = (c_rd == '0);  // reserved jr or ebreak
                  end
               end
               C2_F3_SWSP: o_instr32 = enc_s(swsp_off, c_rs2, REG_SP);
               default:    o_illegal = 1'b1; // fp and rv64 sp forms
            endcase
         end
         FULL: ;
      endcase
   end

endmodule

`default_nettype wire

// File: hw/imm_gen.sv
`default_nettype none

module imm_gen import rv_isa_pkg::*; (
   input  logic [31:0] i_instr32,
   output logic [31:0] o_imm
);

   logic [31:0] w;                           // short alias for the bit slicing
   logic        sgn;

   assign w   = i_instr32;
   assign sgn = i_instr32[31];               // every format signs from bit 31

   always_comb begin
      case (opcode_e'(w[6:2]))
         OP_STORE: begin                     // s-type
            o_imm = {{(XLEN-12){sgn}}, w[31:25], w[11:7]};
         end
         OP_BRANCH: begin                    // b-type, even offsets
            o_imm = {{(XLEN-13){sgn}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
         end
         OP_LUI, OP_AUIPC: begin             // u-type
            o_imm = {w[31:12], 12'b0};
         end
         OP_JAL: begin                       // j-type
            o_imm = {{(XLEN-21){sgn}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
         end
         default: begin                      // i-type, meaningless for r-type
            o_imm = {{(XLEN-12){sgn}}, w[31:20]};
         end
      endcase
   end

endmodule

`default_nettype wire

// File: hw/funct_decode.sv
`default_nettype none

module funct_decode import rv_isa_pkg::*, decode_pkg::*; (
   input  logic [31:0] i_instr32,
   input  logic        i_is_branch,
   input  logic        i_use_funct7,         // reg-reg op, full funct7 decode
   output alu_op_e     o_alu_op,
   output logic [5:0]  o_branch_mask
);

   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       is_opimm;
   logic       alt;                          // sub / sra select

   assign funct3   = i_instr32[14:12];
   assign funct7   = i_instr32[31:25];
   assign is_opimm = (opcode_e'(i_instr32[6:2]) == OP_OPIMM);
   assign alt      = i_use_funct7 ? (funct7 == FUNCT7_ALT) : funct7[5];

   always_comb begin
      o_alu_op = ALU_ADD;                    // address calc, jumps, lui etc
      if (i_use_funct7 && (funct7 == FUNCT7_MULDIV)) begin
         case (funct3)
            F3_ADD_SUB: o_alu_op = ALU_MUL;
            F3_SLL:     o_alu_op = ALU_MULH;
            F3_SLT:     o_alu_op = ALU_MULHSU;
            F3_SLTU:    o_alu_op = ALU_MULHU;
            F3_XOR:     o_alu_op = ALU_DIV;
            F3_SRL_SRA: o_alu_op = ALU_DIVU;
            F3_OR:      o_alu_op = ALU_REM;
            default:    o_alu_op = ALU_REMU;
         endcase
      end else if (i_use_funct7 || is_opimm) begin
         case (funct3)
            F3_ADD_SUB: o_alu_op = (i_use_funct7 && alt) ? ALU_SUB : ALU_ADD;  // no subi
            F3_SLL:     o_alu_op = ALU_SLL;
            F3_SLT:     o_alu_op = ALU_SLT;
            F3_SLTU:    o_alu_op = ALU_SLTU;
            F3_XOR:     o_alu_op = ALU_XOR;
            F3_SRL_SRA: o_alu_op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      o_alu_op = ALU_OR;
            default:    o_alu_op = ALU_AND;
         endcase
      end
   end

   always_comb begin
      o_branch_mask = '0;
      if (i_is_branch) begin
         case (funct3)
            F3_BEQ:  o_branch_mask[0] = 1'b1;
            F3_BNE:  o_branch_mask[1] = 1'b1;
            F3_BLT:  o_branch_mask[2] = 1'b1;
            F3_BGE:  o_branch_mask[3] = 1'b1;
            F3_BLTU: o_branch_mask[4] = 1'b1;
            F3_BGEU: o_branch_mask[5] = 1'b1;
            default: o_branch_mask    = '0;  // 010 and 011 not defined
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hw/exec_control.sv
`default_nettype none

module exec_control import rv_isa_pkg::*, decode_pkg::*; (
   input  opcode_e    i_opcode,
   input  logic       i_illegal,             // unsupported compressed form
   output exec_ctrl_t o_ctrl,
   output logic       o_is_branch,
   output logic       o_use_funct7
);

   assign o_is_branch  = !i_illegal && (i_opcode == OP_BRANCH);
   assign o_use_funct7 = !i_illegal && (i_opcode == OP_OP);

   always_comb begin
      o_ctrl = '0;                           // regval1/regval2, fetch, no writeback
      if (i_illegal) begin
         o_ctrl.next_stage = EXEC_TRAP;
      end else begin
         case (i_opcode)
            OP_OP: begin
               o_ctrl.wb_from_alu = 1'b1;    // result written in fetch
            end
            OP_OPIMM: begin
               o_ctrl.s2_sel      = S2_IMM;
               o_ctrl.wb_from_alu = 1'b1;
            end
            OP_LOAD: begin                   // alu forms the address
               o_ctrl.s2_sel     = S2_IMM;
               o_ctrl.next_stage = EXEC_LOAD;
            end
            OP_STORE: begin
               o_ctrl.s2_sel     = S2_IMM;
               o_ctrl.next_stage = EXEC_STORE;
            end
            OP_JAL, OP_JALR: begin
               // link written during decode, alu computes target
               o_ctrl.s1_sel           = (i_opcode == OP_JAL) ? S1_PC : S1_REGVAL1;
               o_ctrl.s2_sel           = S2_IMM;
               o_ctrl.write_reg        = 1'b1;
               o_ctrl.reg_in_sel       = REGIN_ALU;
               o_ctrl.next_pc_from_alu = 1'b1;
            end
            OP_BRANCH: begin                 // compare on regval1/regval2
               o_ctrl.next_stage = EXEC_BRANCH;
            end
            OP_AUIPC: begin                  // pc + imm
               o_ctrl.s1_sel      = S1_PC;
               o_ctrl.s2_sel      = S2_IMM;
               o_ctrl.wb_from_alu = 1'b1;
            end
            OP_LUI: begin
               o_ctrl.wb_from_imm = 1'b1;
               o_ctrl.reg_in_sel  = REGIN_IMM;
            end
            OP_MISCMEM: ;                    // fence is a nop here
            OP_SYSTEM: begin
               o_ctrl.next_stage = EXEC_SYSTEM;
            end
            default: begin
               o_ctrl.next_stage = EXEC_TRAP;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hw/instr_decoder.sv
`default_nettype none

module instr_decoder import rv_isa_pkg::*, decode_pkg::*; (
   input  logic        i_clk,
   input  logic        i_rst,
   input  logic        i_en,                 // decode strobe
   input  logic [31:0] i_instr,
   output logic        o_valid,              // one cycle after each strobe
   output decode_out_t o_dec
);

   logic [31:0] instr32;                     // expanded instruction
   logic        illegal;
   opcode_e     opcode;
   logic [31:0] imm;
   alu_op_e     alu_op;
   logic [5:0]  branch_mask;
   exec_ctrl_t  ctrl;
   logic        is_branch;
   logic        use_funct7;
   decode_out_t dec_next;

   assign opcode = opcode_e'(instr32[6:2]);

   rvc_expand u_expand (.i_instr(i_instr), .o_instr32(instr32), .o_illegal(illegal));

   imm_gen u_imm (.i_instr32(instr32), .o_imm(imm));

   exec_control u_ctrl (.i_opcode(opcode), .i_illegal(illegal), .o_ctrl(ctrl),
                        .o_is_branch(is_branch), .o_use_funct7(use_funct7));

   funct_decode u_funct (.i_instr32(instr32), .i_is_branch(is_branch),
                         .i_use_funct7(use_funct7), .o_alu_op(alu_op),
                         .o_branch_mask(branch_mask));

   assign dec_next.rs1         = instr32[19:15];  // fixed fields after expansion
   assign dec_next.rs2         = instr32[24:20];
   assign dec_next.rd          = instr32[11:7];
   assign dec_next.imm         = imm;
   assign dec_next.alu_op      = alu_op;
   assign dec_next.branch_mask = branch_mask;
   assign dec_next.funct3      = instr32[14:12];
   assign dec_next.ctrl        = ctrl;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_valid <= 1'b0;
         o_dec   <= '0;                      // ctrl back to fetch, no writes
      end else begin
         o_valid <= i_en;
         if (i_en) begin
            o_dec <= dec_next;               // held while i_en low
         end
      end
   end

endmodule

`default_nettype wire

// File: bench/tb_encode.svh
`ifndef TB_ENCODE_SVH
`define TB_ENCODE_SVH

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input opcode_e op);
   return {f7, rs2, rs1, f3, rd, op, 2'b11};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input opcode_e op);
   return {imm, rs1, f3, rd, op, 2'b11};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
   return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE, 2'b11};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
   return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH, 2'b11};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input opcode_e op);
   return {imm, rd, op, 2'b11};                 // lui / auipc
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL, 2'b11};
endfunction

// compressed encoders, halfword returned in the low 16 bits
function automatic logic [15:0] c_ci(input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [5:0] imm);
   return {f3, imm[5], rd, imm[4:0], 2'b01};    // addi, li, lui
endfunction

function automatic logic [15:0] c_cl(input logic [2:0] f3, input logic [6:0] off,
                                     input logic [2:0] rs1p, input logic [2:0] rp);
   return {f3, off[5:3], rs1p, off[2], off[6], rp, 2'b00};  // c.lw / c.sw
endfunction

function automatic logic [15:0] c_cj(input logic [2:0] f3, input logic [11:0] off);
   return {f3, off[11], off[4], off[9:8], off[10], off[6], off[7], off[3:1], off[5], 2'b01};
endfunction

function automatic logic [15:0] c_lwsp(input logic [4:0] rd, input logic [7:0] off);
   return {3'b010, off[5], rd, off[4:2], off[7:6], 2'b10};
endfunction

function automatic logic [15:0] c_swsp(input logic [4:0] rs2, input logic [7:0] off);
   return {3'b110, off[5:2], off[7:6], rs2, 2'b10};
endfunction

function automatic logic [15:0] c_cr(input logic b12, input logic [4:0] rd,
                                     input logic [4:0] rs2);
   return {3'b100, b12, rd, rs2, 2'b10};        // jr, mv, jalr, add
endfunction

`endif

// File: bench/tb_instr_decoder.sv
`default_nettype none

module tb_instr_decoder import rv_isa_pkg::*, decode_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   `include "tb_encode.svh"

   localparam int TIMEOUT = 4000;            // cycle limit with wide margin

   logic        i_clk;
   logic        i_rst;
   logic        i_en;
   logic [31:0] i_instr;
   logic        o_valid;
   decode_out_t o_dec;
   int          cycles;
   logic [31:0] seed_val;

   instr_decoder i_dut (.i_clk(i_clk), .i_rst(i_rst), .i_en(i_en), .i_instr(i_instr),
                        .o_valid(o_valid), .o_dec(o_dec));

   initial i_clk = 1'b0;
   always #10 i_clk = ~i_clk;                // 20 ns period

   always @(posedge i_clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT) begin
         $display("timeout: no finish after %0d cycles", cycles);
         $display("Simulation failed");
         $fatal(1, "run aborted on timeout");
      end
   end

   task automatic fail_run(input string msg);
      $display("ERR %0t: %s", $time, msg);
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_ctrl(input exec_ctrl_t got, input exec_ctrl_t exp, input string what);
      if (got !== exp) fail_run($sformatf("%s ctrl got %h exp %h", what, got, exp));
   endtask

   task automatic check_alu(input alu_op_e got, input alu_op_e exp, input string what);
      if (got !== exp) begin
         fail_run($sformatf("%s alu_op got %s exp %s", what, got.name(), exp.name()));
      end
   endtask

   task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) fail_run($sformatf("%s got %h exp %h", what, got, exp));
   endtask

   task automatic check_reg(input logic [4:0] got, input logic [4:0] exp, input string what);
      if (got !== exp) fail_run($sformatf("%s reg got x%0d exp x%0d", what, got, exp));
   endtask

   function automatic logic [31:0] rnd();
      return $urandom();
   endfunction

   function automatic alu_op_e base_op(input logic [2:0] f3);
      case (f3)
         3'd0: return ALU_ADD;
         3'd1: return ALU_SLL;
         3'd2: return ALU_SLT;
         3'd3: return ALU_SLTU;
         3'd4: return ALU_XOR;
         3'd5: return ALU_SRL;
         3'd6: return ALU_OR;
         default: return ALU_AND;
      endcase
   endfunction

   function automatic alu_op_e muldiv_op(input logic [2:0] f3);
      case (f3)
         3'd0: return ALU_MUL;
         3'd1: return ALU_MULH;
         3'd2: return ALU_MULHSU;
         3'd3: return ALU_MULHU;
         3'd4: return ALU_DIV;
         3'd5: return ALU_DIVU;
         3'd6: return ALU_REM;
         default: return ALU_REMU;
      endcase
   endfunction

   // strobes i_en for one cycle and waits for o_valid
   task automatic run_decode(input logic [31:0] instr, output decode_out_t d);
      i_instr = instr;
      i_en    = 1'b1;
      @(posedge i_clk);
      #1;
      i_en = 1'b0;
      while (!o_valid) begin                 // timeout counter guards this
         @(posedge i_clk);
         #1;
      end
      d = o_dec;
   endtask

   task automatic compare_dec(input decode_out_t got, input decode_out_t exp, input string what);
      check_reg(got.rs1, exp.rs1, {what, " rs1"});
      check_reg(got.rs2, exp.rs2, {what, " rs2"});
      check_reg(got.rd, exp.rd, {what, " rd"});
      check_word(got.imm, exp.imm, {what, " imm"});
      check_alu(got.alu_op, exp.alu_op, what);
      check_word({26'b0, got.branch_mask}, {26'b0, exp.branch_mask}, {what, " mask"});
      check_word({29'b0, got.funct3}, {29'b0, exp.funct3}, {what, " funct3"});
      check_ctrl(got.ctrl, exp.ctrl, what);
   endtask

   task automatic alu_op_table();
      decode_out_t d;
      exec_ctrl_t  exp;
      logic [2:0]  f3;
      logic [6:0]  f7;
      for (int i = 0; i < 8; i++) begin
         f3 = i[2:0];
         exp = '0;
         exp.wb_from_alu = 1'b1;             // op results go back in fetch
         run_decode(enc_r(FUNCT7_BASE, 5'd3, 5'd4, f3, 5'd5, OP_OP), d);
         check_alu(d.alu_op, base_op(f3), "op base");
         check_ctrl(d.ctrl, exp, "op base");
         run_decode(enc_r(FUNCT7_ALT, 5'd3, 5'd4, f3, 5'd5, OP_OP), d);
         check_alu(d.alu_op, (f3 == 3'd0) ? ALU_SUB : (f3 == 3'd5) ? ALU_SRA : base_op(f3),
                   "op alt");
         run_decode(enc_r(FUNCT7_MULDIV, 5'd3, 5'd4, f3, 5'd5, OP_OP), d);
         check_alu(d.alu_op, muldiv_op(f3), "op muldiv");
         check_ctrl(d.ctrl, exp, "op muldiv");
         for (int a = 0; a < 2; a++) begin   // imm bit 10 only matters for srai
            f7 = (a == 1) ? FUNCT7_ALT : FUNCT7_BASE;
            run_decode(enc_i({f7, 5'd7}, 5'd6, f3, 5'd9, OP_OPIMM), d);
            check_alu(d.alu_op, (f3 == 3'd5 && a == 1) ? ALU_SRA : base_op(f3), "opimm");
         end
      end
   endtask

   task automatic immediate_fields();
      decode_out_t d;
      exec_ctrl_t  exp;
      logic [31:0] r;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [4:0]  rd;
      for (int n = 0; n < 10; n++) begin
         r   = rnd();
         rs1 = r[4:0];
         rs2 = r[9:5];
         rd  = r[14:10];
         r   = rnd();
         run_decode(enc_i(r[11:0], rs1, 3'd0, rd, OP_OPIMM), d);  // addi
         check_word(d.imm, {{20{r[11]}}, r[11:0]}, "i imm");
         check_reg(d.rs1, rs1, "i");
         check_reg(d.rd, rd, "i");
         run_decode(enc_s(r[23:12], rs2, rs1, F3_SW), d);
         check_word(d.imm, {{20{r[23]}}, r[23:12]}, "s imm");
         check_reg(d.rs1, rs1, "s");
         check_reg(d.rs2, rs2, "s");
         check_word({29'b0, d.funct3}, {29'b0, F3_SW}, "s funct3");
         exp = '0;
         exp.s2_sel     = S2_IMM;             // address is rs1 plus imm
         exp.next_stage = EXEC_STORE;
         check_ctrl(d.ctrl, exp, "store");
         r = rnd();
         run_decode(enc_b({r[11:0], 1'b0}, rs2, rs1, F3_BNE), d);
         check_word(d.imm, {{19{r[11]}}, r[11:0], 1'b0}, "b imm");
         check_reg(d.rs1, rs1, "b");
         check_reg(d.rs2, rs2, "b");
         r = rnd();
         run_decode(enc_u(r[19:0], rd, n[0] ? OP_AUIPC : OP_LUI), d);
         check_word(d.imm, {r[19:0], 12'b0}, "u imm");
         check_reg(d.rd, rd, "u");
         check_word({30'b0, d.ctrl.wb_from_alu, d.ctrl.wb_from_imm}, {30'b0, n[0], !n[0]},
                    "u writeback source");   // auipc via alu, lui from imm
         r = rnd();
         run_decode(enc_j({r[19:0], 1'b0}, rd), d);
         check_word(d.imm, {{11{r[19]}}, r[19:0], 1'b0}, "j imm");
         check_reg(d.rd, rd, "j");
         exp = '0;
         exp.s1_sel           = S1_PC;       // target is pc plus imm
         exp.s2_sel           = S2_IMM;
         exp.next_pc_from_alu = 1'b1;
         exp.reg_in_sel       = REGIN_ALU;
         exp.write_reg        = 1'b1;        // link register
         check_ctrl(d.ctrl, exp, "jal");
      end
   endtask

   task automatic branch_masks();
      decode_out_t d;
      exec_ctrl_t  exp;
      logic [5:0]  mask;
      logic [2:0]  f3s [6];
      f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};  // beq..bgeu
      for (int k = 0; k < 6; k++) begin
         mask    = '0;
         mask[k] = 1'b1;
         exp = '0;
         exp.next_stage = EXEC_BRANCH;
         run_decode(enc_b(13'h0010, 5'd2, 5'd1, f3s[k]), d);
         check_word({26'b0, d.branch_mask}, {26'b0, mask}, "branch mask");
         check_ctrl(d.ctrl, exp, "branch");
      end
      exp = '0;
      exp.s2_sel     = S2_IMM;
      exp.next_stage = EXEC_LOAD;
      run_decode(enc_i(12'h004, 5'd1, 3'b000, 5'd2, OP_LOAD), d);  // funct3 like beq
      check_word({26'b0, d.branch_mask}, 32'd0, "load mask");
      check_ctrl(d.ctrl, exp, "load");
      run_decode(enc_r(FUNCT7_BASE, 5'd1, 5'd2, 3'b001, 5'd3, OP_OP), d);
      check_word({26'b0, d.branch_mask}, 32'd0, "op mask");
   endtask

   task automatic same_as_expansion(input logic [15:0] c, input logic [31:0] full,
                                    input string what);
      decode_out_t dc;
      decode_out_t df;
      run_decode({16'h0000, c}, dc);
      run_decode(full, df);
      compare_dec(dc, df, what);
   endtask

   task automatic compressed_forms();
      decode_out_t d;
      logic [31:0] r;
      logic [4:0]  rd;
      logic [4:0]  rs2;
      logic [2:0]  p1;
      logic [2:0]  p2;
      for (int n = 0; n < 6; n++) begin
         r   = rnd();
         rd  = (r[4:0] == 5'd0 || r[4:0] == 5'd2) ? 5'd7 : r[4:0];  // legal for all forms
         rs2 = (r[9:5] == 5'd0) ? 5'd11 : r[9:5];
         p1  = r[12:10];
         p2  = r[15:13];
         r   = rnd();
         same_as_expansion(c_cl(3'b010, {r[4:0], 2'b00}, p1, p2),
                           enc_i({5'b0, r[4:0], 2'b00}, {2'b01, p1}, F3_LW, {2'b01, p2},
                                 OP_LOAD), "c.lw");
         same_as_expansion(c_cl(3'b110, {r[4:0], 2'b00}, p1, p2),
                           enc_s({5'b0, r[4:0], 2'b00}, {2'b01, p2}, {2'b01, p1}, F3_SW),
                           "c.sw");
         same_as_expansion(c_ci(3'b000, rd, r[10:5]),
                           enc_i({{6{r[10]}}, r[10:5]}, rd, 3'b000, rd, OP_OPIMM), "c.addi");
         same_as_expansion(c_ci(3'b010, rd, r[10:5]),
                           enc_i({{6{r[10]}}, r[10:5]}, 5'd0, 3'b000, rd, OP_OPIMM), "c.li");
         same_as_expansion(c_ci(3'b011, rd, {r[10:6], 1'b1}),
                           enc_u({{14{r[10]}}, r[10:6], 1'b1}, rd, OP_LUI), "c.lui");
         same_as_expansion(c_cj(3'b001, {r[21:11], 1'b0}),
                           enc_j({{9{r[21]}}, r[21:11], 1'b0}, REG_RA), "c.jal");
         same_as_expansion(c_cj(3'b101, {r[21:11], 1'b0}),
                           enc_j({{9{r[21]}}, r[21:11], 1'b0}, 5'd0), "c.j");
         same_as_expansion(c_ci(3'b000, rd, {1'b0, r[26:22]}) ^ 16'h0003,  // q2 slli
                           enc_i({7'b0, r[26:22]}, rd, F3_SLL, rd, OP_OPIMM), "c.slli");
         same_as_expansion(c_lwsp(rd, {r[5:0], 2'b00}),
                           enc_i({4'b0, r[5:0], 2'b00}, REG_SP, F3_LW, rd, OP_LOAD), "c.lwsp");
         same_as_expansion(c_swsp(rs2, {r[5:0], 2'b00}),
                           enc_s({4'b0, r[5:0], 2'b00}, rs2, REG_SP, F3_SW), "c.swsp");
         same_as_expansion(c_cr(1'b0, rd, 5'd0),
                           enc_i(12'd0, rd, F3_JALR, 5'd0, OP_JALR), "c.jr");
         same_as_expansion(c_cr(1'b1, rd, 5'd0),
                           enc_i(12'd0, rd, F3_JALR, REG_RA, OP_JALR), "c.jalr");
         same_as_expansion(c_cr(1'b0, rd, rs2),
                           enc_r(FUNCT7_BASE, rs2, 5'd0, 3'b000, rd, OP_OP), "c.mv");
         same_as_expansion(c_cr(1'b1, rd, rs2),
                           enc_r(FUNCT7_BASE, rs2, rd, 3'b000, rd, OP_OP), "c.add");
      end
      same_as_expansion(16'h0001, enc_i(12'd0, 5'd0, 3'b000, 5'd0, OP_OPIMM), "c.nop");
      run_decode({16'h0000, c_cl(3'b010, 7'h04, 3'd0, 3'd7)}, d);
      check_reg(d.rs1, 5'd8, "c.lw rs1'");    // compact regs start at x8
      check_reg(d.rd, 5'd15, "c.lw rd'");
      run_decode({16'h0000, c_cj(3'b001, 12'h010)}, d);
      check_reg(d.rd, REG_RA, "c.jal link");
      if (d.ctrl.write_reg !== 1'b1) fail_run("c.jal does not write the link register");
   endtask

   task automatic expect_trap(input logic [31:0] instr, input string what);
      decode_out_t d;
      exec_ctrl_t  exp;
      exp = '0;
      exp.next_stage = EXEC_TRAP;            // no writeback of any kind
      run_decode(instr, d);
      check_ctrl(d.ctrl, exp, what);
   endtask

   task automatic illegal_forms();
      expect_trap(32'h0000_0040, "c.addi4spn");
      expect_trap({16'h0, c_ci(3'b011, REG_SP, 6'h10)}, "c.addi16sp");
      expect_trap(32'h0000_8c05, "c.sub");
      expect_trap(32'h0000_8001, "c.srli");
      expect_trap(32'h0000_c001, "c.beqz");
      expect_trap(32'h0000_e001, "c.bnez");
      expect_trap(32'h0000_9002, "c.ebreak");
      expect_trap(32'h0000_8002, "c.jr x0");
      expect_trap({16'h0, c_lwsp(5'd0, 8'h04)}, "c.lwsp x0");
      expect_trap({16'h0, c_ci(3'b011, 5'd5, 6'h00)}, "c.lui zero");
      expect_trap(32'h0000_1296, "c.slli bit12");
      expect_trap(32'h0000_2000, "c.fld");
      expect_trap(32'h0000_6002, "c.flwsp");
      expect_trap(32'h0000_007f, "opcode 11111");
      expect_trap(32'h0000_000b, "custom-0");
   endtask

   task automatic valid_and_hold();
      decode_out_t held;
      for (int k = 0; k < 3; k++) begin
         i_instr = enc_i(12'(k + 1), 5'd0, 3'b000, 5'(k + 5), OP_OPIMM);
         i_en    = 1'b1;
         @(posedge i_clk);
         #1;
         if (o_valid !== 1'b1) fail_run("o_valid low during back-to-back decode");
         check_reg(o_dec.rd, 5'(k + 5), "back-to-back");
         check_word(o_dec.imm, 32'(k + 1), "back-to-back imm");
      end
      i_en    = 1'b0;
      i_instr = 32'h0000_0073;               // ecall that must not be taken
      held    = o_dec;
      for (int k = 0; k < 4; k++) begin
         @(posedge i_clk);
         #1;
         if (o_valid !== 1'b0) fail_run("o_valid high while i_en low");
         if (o_dec !== held) fail_run("o_dec changed while i_en low");
      end
   endtask

   initial begin
      seed_val   = $urandom(32'h5f6ec32f);   // seeds the generator once
      cycles     = 0;
      i_rst      = 1'b1;
      i_en       = 1'b0;
      i_instr    = 32'h0;
      repeat (2) @(posedge i_clk);
      #1;
      i_rst = 1'b0;
      if (o_valid !== 1'b0) fail_run("o_valid high after reset");
      compare_dec(o_dec, '0, "reset");      // every field cleared with fetch next
      alu_op_table();
      immediate_fields();
      branch_masks();
      compressed_forms();
      illegal_forms();
      valid_and_hold();
      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
+incdir+bench
hw/rv_isa_pkg.sv
hw/decode_pkg.sv
hw/rvc_expand.sv
hw/imm_gen.sv
hw/funct_decode.sv
hw/exec_control.sv
hw/instr_decoder.sv
bench/tb_instr_decoder.sv

// File: Makefile
SRCS := $(shell grep -v '^+' sim.f) bench/tb_encode.svh

.PHONY: all run clean

all: run

obj_dir/Vtb_instr_decoder: $(SRCS) sim.f
	verilator --binary --timing -f sim.f --top-module tb_instr_decoder -o Vtb_instr_decoder

run: obj_dir/Vtb_instr_decoder
	-./obj_dir/Vtb_instr_decoder > sim.log 2>&1
	@cat sim.log
	@grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
